// File: filelist.f
verilog/spi_bus_pkg.sv
verilog/sample_pkg.sv
verilog/uart_tx.sv
verilog/spi_master.sv
verilog/sample_acquirer.sv
verilog/credit_fifo.sv
verilog/frame_sender.sv
verilog/sensor_bridge_top.sv
dv/spi_sensor_model.sv
dv/tb_sensor_bridge.sv

// File: Makefile
TB_TOP  = tb_sensor_bridge
OBJ_DIR = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module sensor_bridge_top

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_sensor_bridge.sv
`timescale 1ns/1ns

module tb_sensor_bridge import spi_bus_pkg::*; import sample_pkg::*; ();
    localparam int CLK_DIV       = 2;
    // Well below one UART frame, so the FIFO fills and credits run out
    localparam int SAMPLE_PERIOD = 120;
    localparam int FIFO_DEPTH    = 4;
    localparam int CLKS_PER_BIT  = 8;
    localparam int NUM_FRAMES    = 16;
    localparam int START_TIMEOUT = 2000;

    logic       clk;
    logic       rst;
    logic       spi_sclk;
    logic       spi_cs_n;
    logic       spi_mosi;
    logic       spi_miso;
    logic       uart_tx;
    logic [7:0] cmd_byte;
    int         sclk_rises;
    int         errors;
    int         windows;
    int         frames_begun;
    int         frames_checked;
    logic       timed_out;
    logic [7:0] frame_bytes [4];

    sensor_bridge_top #(
        .CLK_DIV      (CLK_DIV),
        .SAMPLE_PERIOD(SAMPLE_PERIOD),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_dut (
        .clk       (clk),
        .i_rst     (rst),
        .o_spi_sclk(spi_sclk),
        .o_spi_cs_n(spi_cs_n),
        .o_spi_mosi(spi_mosi),
        .i_spi_miso(spi_miso),
        .o_uart_tx (uart_tx)
    );

    spi_sensor_model i_sensor (
        .clk         (clk),
        .i_sclk      (spi_sclk),
        .i_cs_n      (spi_cs_n),
        .i_mosi      (spi_mosi),
        .o_miso      (spi_miso),
        .o_cmd_byte  (cmd_byte),
        .o_sclk_rises(sclk_rises)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic flag_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // Read starts, one per chip-select fall
    always @(negedge spi_cs_n) begin
        if (!rst) begin
            windows++;
        end
    end

    // Idle pins while reset is applied and on the cycle after
    a_reset_idle: assert property (@(posedge clk) $past(rst) |-> spi_cs_n && !spi_sclk && uart_tx)
        else flag_error("SPI or UART pins not idle around reset");

    a_window_shape: assert property (@(posedge clk) disable iff (rst)
        $rose(spi_cs_n) |-> sclk_rises == 8 * SPI_BYTES_PER_READ && cmd_byte == READ_CMD)
        else flag_error($sformatf("window with %0d sclk rises, command %h", sclk_rises, cmd_byte));

    // FIFO slots, one read in flight and the sample held in the sender
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        windows <= frames_begun + FIFO_DEPTH + 1)
        else flag_error($sformatf("%0d windows against %0d frames", windows, frames_begun));

    // 8N1 byte sampled mid-bit, ok drops only on a missing start bit
    task automatic receive_byte(input bit first, output logic [7:0] data, output bit ok);
        int waited;
        waited = 0;
        ok     = 1'b1;
        data   = '0;
        while (uart_tx !== 1'b0 && waited < START_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (uart_tx !== 1'b0) begin
            $display("Timeout: no UART start bit within %0d clock cycles", START_TIMEOUT);
            ok = 1'b0;
        end else begin
            if (first) begin
                frames_begun++;
            end
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            assert (uart_tx == 1'b0) else flag_error("UART start bit too short");
            // LSB first
            for (int b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                data[b] = uart_tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            assert (uart_tx == 1'b1) else flag_error("UART stop bit missing");
        end
    endtask

    // Sync, sequence, then the oldest word the sensor sent
    task automatic check_frame(input int idx);
        logic [15:0]      expected;
        logic [SEQ_W-1:0] expected_seq;
        expected_seq = SEQ_W'(idx);
        assert (frame_bytes[0] == FRAME_SYNC)
            else flag_error($sformatf("frame %0d sync %h, expected %h", idx, frame_bytes[0],
                                      FRAME_SYNC));
        assert (frame_bytes[1] == 8'(expected_seq))
            else flag_error($sformatf("frame %0d sequence %h, expected %h", idx, frame_bytes[1],
                                      expected_seq));
        if (i_sensor.expected_words.size() == 0) begin
            flag_error($sformatf("frame %0d arrived with no sensor word pending", idx));
        end else begin
            expected = i_sensor.expected_words.pop_front();
            assert ({frame_bytes[2], frame_bytes[3]} == expected)
                else flag_error($sformatf("frame %0d data %h%h, expected %h", idx,
                                          frame_bytes[2], frame_bytes[3], expected));
        end
        frames_checked++;
    endtask

    initial begin
        bit ok;
        rst            = 1'b1;
        errors         = 0;
        windows        = 0;
        frames_begun   = 0;
        frames_checked = 0;
        timed_out      = 1'b0;
        ok             = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int f = 0; f < NUM_FRAMES && !timed_out; f++) begin
            for (int k = 0; k < 4 && !timed_out; k++) begin
                receive_byte(k == 0, frame_bytes[k], ok);
                timed_out = !ok;
            end
            if (!timed_out) begin
                check_frame(f);
            end
        end
        $display("Frames checked: %0d, SPI windows: %0d, errors: %0d",
                 frames_checked, windows, errors);
        if (errors == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: dv/spi_sensor_model.sv
`timescale 1ns/1ns

module spi_sensor_model #(
    parameter logic [15:0] SEED = 16'd90
) (
    input  logic       clk,
    input  logic       i_sclk,
    input  logic       i_cs_n,
    input  logic       i_mosi,
    output logic       o_miso,
    output logic [7:0] o_cmd_byte,
    output int         o_sclk_rises
);
    logic [15:0] lfsr;
    logic [15:0] word;
    // Zero byte under the command, then the data word MSB first
    logic [23:0] miso_shift;
    logic        cs_q;
    logic        sclk_q;
    // Words in the order they went out, oldest at the front
    logic [15:0] expected_words [$];

    // Fibonacci form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    initial begin
        lfsr         = SEED;
        word         = '0;
        miso_shift   = '0;
        cs_q         = 1'b1;
        sclk_q       = 1'b0;
        o_miso       = 1'b0;
        o_cmd_byte   = '0;
        o_sclk_rises = 0;
    end

    // SPI pins move on rising clk, so edges are picked up half a cycle later
    always @(negedge clk) begin
        if (cs_q && !i_cs_n) begin
            // One LFSR step per data bit
            for (int b = 0; b < 16; b++) begin
                lfsr = lfsr_next(lfsr);
                word = {word[14:0], lfsr[0]};
            end
            expected_words.push_back(word);
            miso_shift   = {8'h00, word};
            o_miso       = miso_shift[23];
            o_sclk_rises = 0;
        end else if (!sclk_q && i_sclk) begin
            // Command byte comes on the first eight rises
            if (o_sclk_rises < 8) begin
                o_cmd_byte = {o_cmd_byte[6:0], i_mosi};
            end
            o_sclk_rises++;
        end else if (sclk_q && !i_sclk) begin
            miso_shift = {miso_shift[22:0], 1'b0};
            o_miso     = miso_shift[23];
        end
        cs_q   = i_cs_n;
        sclk_q = i_sclk;
    end

endmodule

// File: verilog/sensor_bridge_top.sv
`timescale 1ns/1ns

module sensor_bridge_top import spi_bus_pkg::*; import sample_pkg::*; #(
    parameter int CLK_DIV       = 4,
    parameter int SAMPLE_PERIOD = 2000,
    parameter int FIFO_DEPTH    = 4,
    parameter int CLKS_PER_BIT  = 104
) (
    input  logic clk,
    input  logic i_rst,
    output logic o_spi_sclk,
    output logic o_spi_cs_n,
    output logic o_spi_mosi,
    input  logic i_spi_miso,
    output logic o_uart_tx
);
    // Acquirer to SPI master
    logic       spi_start;
    spi_xfer_t  spi_xfer;
    logic       spi_ready;
    logic       rx_valid;
    logic [7:0] rx_byte;
    logic [1:0] rx_index;
    logic       spi_done;

    // Acquirer to FIFO, credits back
    logic       push;
    sample_t    push_sample;
    logic       credit;

    // FIFO head to sender
    logic       head_valid;
    sample_t    head_sample;
    logic       pop;

    spi_master #(
        .CLK_DIV(CLK_DIV)
    ) u_spi_master (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_start   (spi_start),
        .i_xfer    (spi_xfer),
        .o_ready   (spi_ready),
        .o_rx_valid(rx_valid),
        .o_rx_byte (rx_byte),
        .o_rx_index(rx_index),
        .o_done    (spi_done),
        .o_spi_sclk(o_spi_sclk),
        .o_spi_mosi(o_spi_mosi),
        .o_spi_cs_n(o_spi_cs_n),
        .i_spi_miso(i_spi_miso)
    );

    sample_acquirer #(
        .SAMPLE_PERIOD(SAMPLE_PERIOD),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) u_sample_acquirer (
        .clk        (clk),
        .i_rst      (i_rst),
        .o_spi_start(spi_start),
        .o_spi_xfer (spi_xfer),
        .i_spi_ready(spi_ready),
        .i_rx_valid (rx_valid),
        .i_rx_byte  (rx_byte),
        .i_rx_index (rx_index),
        .i_spi_done (spi_done),
        .o_push     (push),
        .o_sample   (push_sample),
        .i_credit   (credit)
    );

    credit_fifo #(
        .DEPTH    (FIFO_DEPTH),
        .T_PAYLOAD(sample_t)
    ) u_credit_fifo (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_push  (push),
        .i_data  (push_sample),
        .o_valid (head_valid),
        .o_data  (head_sample),
        .i_pop   (pop),
        .o_credit(credit)
    );

    frame_sender #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_frame_sender (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_valid  (head_valid),
        .i_sample (head_sample),
        .o_pop    (pop),
        .o_uart_tx(o_uart_tx)
    );

endmodule

// File: verilog/frame_sender.sv
`timescale 1ns/1ns

module frame_sender import sample_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic    clk,
    input  logic    i_rst,
    input  logic    i_valid,
    input  sample_t i_sample,
    output logic    o_pop,
    output logic    o_uart_tx
);
    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_SEND} state_t;

    state_t     state;
    sample_t    sample_q;
    // 0 sync, 1 seq, 2 data high, 3 data low
    logic [1:0] byte_idx;
    logic [7:0] tx_byte;
    logic       tx_start;
    logic       tx_busy;

    // Next byte goes out as soon as the transmitter frees up
    assign tx_start = (state == S_SEND) && !tx_busy;

    always_comb begin
        case (byte_idx)
            2'd0:    tx_byte = FRAME_SYNC;
            2'd1:    tx_byte = 8'(sample_q.seq);
            2'd2:    tx_byte = sample_q.data[15:8];
            default: tx_byte = sample_q.data[7:0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= S_IDLE;
            byte_idx <= '0;
            o_pop    <= 1'b0;
        end else begin
            o_pop <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_valid) begin
                        o_pop <= 1'b1;
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    byte_idx <= '0;
                    state    <= S_SEND;
                end
                default: begin
                    if (tx_start) begin
                        byte_idx <= byte_idx + 2'd1;
                        // Low byte started, frame handed off
                        if (byte_idx == 2'd3) begin
                            state <= S_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // Head sample is taken in the pop cycle
    always_ff @(posedge clk) begin
        if (o_pop) begin
            sample_q <= i_sample;
        end
    end

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_tx (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_start(tx_start),
        .i_byte (tx_byte),
        .o_busy (tx_busy),
        .o_tx   (o_uart_tx)
    );

endmodule

// File: verilog/credit_fifo.sv
`timescale 1ns/1ns

module credit_fifo #(
    parameter int  DEPTH     = 4,
    parameter type T_PAYLOAD = logic [7:0]
) (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_push,
    input  T_PAYLOAD i_data,
    output logic     o_valid,
    output T_PAYLOAD o_data,
    input  logic     i_pop,
    output logic     o_credit
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T_PAYLOAD         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_valid  = (count != '0);
    // Head is read straight from the array
    assign o_data   = mem[rd_ptr];
    assign do_pop   = i_pop && o_valid;
    // Freed slot goes back to the producer in the pop cycle
    assign o_credit = do_pop;

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(i_push) - CNT_W'(do_pop);
        end
    end

    // Producer credit accounting keeps pushes within the free slots
    a_no_overflow: assert property (
        @(posedge clk) disable iff (i_rst) i_push |-> count != CNT_W'(DEPTH));
    // Consumer pops only against valid
    a_no_underflow: assert property (
        @(posedge clk) disable iff (i_rst) i_pop |-> o_valid);

endmodule

// File: verilog/sample_acquirer.sv
`timescale 1ns/1ns

module sample_acquirer import spi_bus_pkg::*; import sample_pkg::*; #(
    parameter int SAMPLE_PERIOD = 1000,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic       clk,
    input  logic       i_rst,
    output logic       o_spi_start,
    output spi_xfer_t  o_spi_xfer,
    input  logic       i_spi_ready,
    input  logic       i_rx_valid,
    input  logic [7:0] i_rx_byte,
    input  logic [1:0] i_rx_index,
    input  logic       i_spi_done,
    output logic       o_push,
    output sample_t    o_sample,
    input  logic       i_credit
);
    localparam int TMR_W = (SAMPLE_PERIOD > 1) ? $clog2(SAMPLE_PERIOD) : 1;
    localparam int CR_W  = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {S_WAIT, S_READ, S_PUSH} state_t;

    state_t           state;
    logic [TMR_W-1:0] timer;
    logic             timer_done;
    // Free FIFO slots as seen from here
    logic [CR_W-1:0]  credits;
    logic [SEQ_W-1:0] seq_cnt;
    logic [15:0]      data_q;

    assign timer_done = (timer == '0);
    // Credit checked up front so the push never stalls
    assign o_spi_start = (state == S_WAIT) && timer_done && i_spi_ready
                         && (credits != '0);
    assign o_spi_xfer  = '{count: 2'(SPI_BYTES_PER_READ), tx_byte: READ_CMD};

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= S_WAIT;
            timer   <= '0;
            credits <= CR_W'(FIFO_DEPTH);
            seq_cnt <= '0;
            o_push  <= 1'b0;
        end else begin
            o_push <= 1'b0;
            // Period counts from each read start
            if (o_spi_start) begin
                timer <= TMR_W'(SAMPLE_PERIOD - 1);
            end else if (!timer_done) begin
                timer <= timer - 1'b1;
            end
            case (state)
                S_WAIT: begin
                    if (o_spi_start) begin
                        state <= S_READ;
                    end
                end
                S_READ: begin
                    if (i_spi_done) begin
                        o_push <= 1'b1;
                        state  <= S_PUSH;
                    end
                end
                default: begin
                    // Extra cycle lets the credit count settle before the next start
                    state <= S_WAIT;
                end
            endcase
            if (o_push) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
            credits <= credits - CR_W'(o_push) + CR_W'(i_credit);
        end
    end

    // Assemble the word, byte 0 is clocked in during the command and dropped
    always_ff @(posedge clk) begin
        if (i_rx_valid && i_rx_index == 2'd1) begin
            data_q[15:8] <= i_rx_byte;
        end
        if (i_rx_valid && i_rx_index == 2'd2) begin
            data_q[7:0] <= i_rx_byte;
        end
        if (state == S_READ && i_spi_done) begin
            o_sample <= '{data: data_q, seq: seq_cnt};
        end
    end

    // FIFO must never return more credits than it has slots
    a_credit_max: assert property (
        @(posedge clk) disable iff (i_rst) credits <= CR_W'(FIFO_DEPTH));
    a_credit_min: assert property (
        @(posedge clk) disable iff (i_rst) o_push |-> credits != '0);

endmodule

// File: verilog/spi_master.sv
`timescale 1ns/1ns

module spi_master import spi_bus_pkg::*; #(
    parameter int CLK_DIV = 4
) (
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_start,
    input  spi_xfer_t  i_xfer,
    output logic       o_ready,
    output logic       o_rx_valid,
    output logic [7:0] o_rx_byte,
    output logic [1:0] o_rx_index,
    output logic       o_done,
    output logic       o_spi_sclk,
    output logic       o_spi_mosi,
    output logic       o_spi_cs_n,
    input  logic       i_spi_miso
);
    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_TAIL, S_DONE} state_t;

    state_t           state;
    logic [DIV_W-1:0] div_cnt;
    logic             half_tick;
    // Counts sclk toggles, two per bit
    logic [5:0]       edge_cnt;
    logic [5:0]       last_edge;
    logic [1:0]       byte_cnt;
    logic [7:0]       tx_shift;
    logic [7:0]       rx_shift;
    logic [2:0]       bit_cnt;
    logic [1:0]       byte_idx;
    // High for the cycle after sclk went high
    logic             sclk_rose;

    assign o_ready   = (state == S_IDLE);
    assign half_tick = (div_cnt == DIV_W'(CLK_DIV - 1));
    // 16 toggles per byte
    assign last_edge = {byte_cnt, 4'b0000} - 6'd1;

    // Sequencing, sclk and chip select
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state      <= S_IDLE;
            div_cnt    <= '0;
            edge_cnt   <= '0;
            sclk_rose  <= 1'b0;
            o_done     <= 1'b0;
            o_spi_cs_n <= 1'b1;
            o_spi_sclk <= 1'b0;
            o_spi_mosi <= 1'b0;
        end else begin
            o_done    <= 1'b0;
            sclk_rose <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        // Mode 0, first bit must be on MOSI before the first rise
                        o_spi_cs_n <= 1'b0;
                        o_spi_mosi <= i_xfer.tx_byte[7];
                        div_cnt    <= '0;
                        edge_cnt   <= '0;
                        state      <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
                    if (half_tick) begin
                        o_spi_sclk <= ~o_spi_sclk;
                        sclk_rose  <= ~o_spi_sclk;
                        edge_cnt   <= edge_cnt + 6'd1;
                        // Falling edge moves the next bit out
                        if (o_spi_sclk) begin
                            o_spi_mosi <= tx_shift[6];
                        end
                        if (edge_cnt == last_edge) begin
                            state <= S_TAIL;
                        end
                    end
                end
                S_TAIL: begin
                    // Hold CS low one more half period after the last fall
                    div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
                    if (half_tick) begin
                        o_spi_cs_n <= 1'b1;
                        state      <= S_DONE;
                    end
                end
                default: begin
                    o_done <= 1'b1;
                    state  <= S_IDLE;
                end
            endcase
        end
    end

    // Bit and byte position in the receive stream
    always_ff @(posedge clk) begin
        if (i_rst) begin
            bit_cnt    <= '0;
            byte_idx   <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            o_rx_valid <= 1'b0;
            if (state == S_IDLE && i_start) begin
                bit_cnt  <= '0;
                byte_idx <= '0;
            end else if (sclk_rose) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    o_rx_valid <= 1'b1;
                    byte_idx   <= byte_idx + 2'd1;
                end
            end
        end
    end

    // Shift registers and received byte
    always_ff @(posedge clk) begin
        if (state == S_IDLE && i_start) begin
            tx_shift <= i_xfer.tx_byte;
            byte_cnt <= i_xfer.count;
        end else if (state == S_SHIFT && half_tick && o_spi_sclk) begin
            // Zero fill, so the data bytes send zeros on MOSI
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
        if (sclk_rose) begin
            rx_shift <= {rx_shift[6:0], i_spi_miso};
            if (bit_cnt == 3'd7) begin
                o_rx_byte  <= {rx_shift[6:0], i_spi_miso};
                o_rx_index <= byte_idx;
            end
        end
    end

    // Caller must wait for ready
    a_start_when_ready: assert property (
        @(posedge clk) disable iff (i_rst) i_start |-> o_ready);

endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_start,
    input  logic [7:0] i_byte,
    output logic       o_busy,
    output logic       o_tx
);
    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic             active;
    logic [CNT_W-1:0] clk_cnt;
    // Bits still to go after the one on the line
    logic [3:0]       bits_left;
    // Data LSB first, stop bit on top
    logic [8:0]       shift_q;
    logic             bit_end;
    logic             frame_end;
    logic             load;

    assign bit_end   = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign frame_end = active && bit_end && (bits_left == 4'd0);
    // Free during the last stop-bit cycle so frames can abut
    assign o_busy    = active && !frame_end;
    assign load      = i_start && !o_busy;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            active    <= 1'b0;
            clk_cnt   <= '0;
            bits_left <= '0;
            o_tx      <= 1'b1;
        end else if (load) begin
            // Start bit
            active    <= 1'b1;
            clk_cnt   <= '0;
            bits_left <= 4'd9;
            o_tx      <= 1'b0;
        end else if (active) begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            if (bit_end) begin
                if (bits_left == 4'd0) begin
                    active <= 1'b0;
                end else begin
                    o_tx      <= shift_q[0];
                    bits_left <= bits_left - 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= {1'b1, i_byte};
        end else if (active && bit_end) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (i_rst) i_start |-> !o_busy);

endmodule

// File: verilog/sample_pkg.sv
// Sample record and UART frame constants
package sample_pkg;

    // Sequence counter width, wraps at 2**SEQ_W
    localparam int SEQ_W = 8;

    // Marks the start of every four-byte frame
    localparam logic [7:0] FRAME_SYNC = 8'hA5;

    // One sensor reading as it travels through the FIFO
    typedef struct packed {
        // Raw sensor word, high byte first on the wire
        logic [15:0]      data;
        // Tag for spotting gaps on the host side
        logic [SEQ_W-1:0] seq;
    } sample_t;

endpackage

// File: verilog/spi_bus_pkg.sv
// Constants and records for the sensor SPI link
package spi_bus_pkg;

    // Command byte, then high and low data bytes
    localparam int SPI_BYTES_PER_READ = 3;

    // Sensor register read opcode, MSB sets the read flag
    localparam logic [7:0] READ_CMD = 8'h8F;

    // One request to the SPI master
    typedef struct packed {
        // Bytes held under a single chip select
        logic [1:0] count;
        // Sent in byte 0, later bytes shift out zeros
        logic [7:0] tx_byte;
    } spi_xfer_t;

endpackage
